// ==== design/panel_pkg.sv ====
/* Panel controller shared types */
`default_nettype none

package panel_pkg;

    // Largest panel the address fields can describe.
    localparam int MAX_WIDTH  = 64;
    localparam int MAX_HEIGHT = 32;

    typedef logic [$clog2(MAX_WIDTH)-1:0]  col_addr_t;
    typedef logic [$clog2(MAX_HEIGHT)-1:0] row_addr_t;
    typedef logic [1:0]                    pixel_sel_t; // 0 red, 1 green, 2 blue.

    typedef struct packed {
        row_addr_t  row;
        col_addr_t  col;
        pixel_sel_t pixel;
    } fb_addr_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } color_t;

    typedef enum logic {
        CMD_BLANK    = 1'b0,
        CMD_FILLRECT = 1'b1
    } cmd_op_t;

    typedef struct packed {
        cmd_op_t    op;
        col_addr_t  x1;
        row_addr_t  y1;
        logic [6:0] width;
        logic [5:0] height;
        color_t     color;
    } draw_cmd_t;

    // One byte write toward the framebuffer.
    typedef struct packed {
        fb_addr_t   addr;
        logic [7:0] data;
        logic       write_enable;
        logic       access_start; // First byte of a pixel.
    } fb_write_t;

endpackage

`default_nettype wire

// ==== design/subcmd_fillarea.sv ====
/* Area fill sequencer */
`timescale 1ns/1ps
`default_nettype none

module subcmd_fillarea import panel_pkg::*; (
    input  wire             clk,
    input  wire             reset,
    input  wire             enable,
    input  wire             ack,
    input  wire col_addr_t  x1,
    input  wire row_addr_t  y1,
    input  wire [6:0]       width,
    input  wire [5:0]       height,
    input  wire color_t     color,
    output fb_write_t       write,
    output logic            done
);

    typedef enum logic [1:0] {
        S_START,
        S_RUN,
        S_DONE
    } fill_state_t;

    fill_state_t state;
    col_addr_t   col_off;
    row_addr_t   row_off;
    pixel_sel_t  pix;
    logic        last_col;
    logic        last_row;
    logic        last_byte;

    assign last_col  = (7'(col_off) == width - 7'd1);
    assign last_row  = (6'(row_off) == height - 6'd1);
    assign last_byte = (pix == 2'd2) && last_col && last_row;

    always_ff @(posedge clk) begin
        if (reset || ack) begin
            state   <= S_START;
            col_off <= '0;
            row_off <= '0;
            pix     <= '0;
        end else begin
            case (state)
                S_START: begin
                    if (enable) begin
                        col_off <= '0;
                        row_off <= '0;
                        pix     <= '0;
                        if (width == 7'd0 || height == 6'd0) begin
                            state <= S_DONE; // Nothing to draw.
                        end else begin
                            state <= S_RUN;
                        end
                    end
                end
                S_RUN: begin
                    if (last_byte) begin
                        state <= S_DONE;
                    end else if (pix != 2'd2) begin
                        pix <= pix + 2'd1;
                    end else begin
                        pix <= 2'd0;
                        if (last_col) begin
                            col_off <= '0;
                            row_off <= row_off + 1'b1;
                        end else begin
                            col_off <= col_off + 1'b1;
                        end
                    end
                end
                S_DONE: begin
                    state <= S_DONE; // Held until the controller acknowledges.
                end
                default: begin
                    state <= S_START;
                end
            endcase
        end
    end

    // The write port follows the counters directly.
    always_comb begin
        write.addr.row   = row_addr_t'(y1 + row_off);
        write.addr.col   = col_addr_t'(x1 + col_off);
        write.addr.pixel = pix;
        case (pix)
            2'd0:    write.data = color.r;
            2'd1:    write.data = color.g;
            default: write.data = color.b;
        endcase
        write.write_enable = (state == S_RUN);
        write.access_start = (state == S_RUN) && (pix == 2'd0);
    end

    assign done = (state == S_DONE);

endmodule

`default_nettype wire

// ==== design/cmd_blankpanel.sv ====
/* Blank panel command */
`timescale 1ns/1ps
`default_nettype none

module cmd_blankpanel import panel_pkg::*; #(
    parameter int PANEL_WIDTH  = 16,
    parameter int PANEL_HEIGHT = 8
) (
    input  wire       clk,
    input  wire       reset,
    input  wire       enable,
    output fb_write_t write,
    output logic      done
);

    typedef enum logic [1:0] {
        ST_START,
        ST_RUNNING,
        ST_PREDONE,
        ST_DONE
    } ctrl_state_t;

    ctrl_state_t state;
    logic        subcmd_enable;
    logic        local_reset;
    logic        fill_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= ST_START;
            subcmd_enable <= 1'b0;
            local_reset   <= 1'b0;
            done          <= 1'b0;
        end else begin
            case (state)
                ST_START: begin
                    if (enable) begin
                        subcmd_enable <= 1'b1;
                        state         <= ST_RUNNING;
                    end
                end
                ST_RUNNING: begin
                    if (enable && fill_done) begin
                        subcmd_enable <= 1'b0;
                        state         <= ST_PREDONE;
                    end
                end
                ST_PREDONE: begin
                    if (enable) begin
                        done        <= 1'b1;
                        local_reset <= 1'b1; // Returns the sequencer to its start state.
                        state       <= ST_DONE;
                    end
                end
                default: begin
                    done        <= 1'b0;
                    local_reset <= 1'b0;
                    state       <= ST_START;
                end
            endcase
        end
    end

    subcmd_fillarea u_fill (
        .clk    (clk),
        .reset  (reset),
        .enable (subcmd_enable),
        .ack    (local_reset),
        .x1     (col_addr_t'(0)),
        .y1     (row_addr_t'(0)),
        .width  (7'(PANEL_WIDTH)),
        .height (6'(PANEL_HEIGHT)),
        .color  (color_t'(0)),
        .write  (write),
        .done   (fill_done)
    );

endmodule

`default_nettype wire

// ==== design/cmd_fillrect.sv ====
/* Fill rectangle command */
`timescale 1ns/1ps
`default_nettype none

module cmd_fillrect import panel_pkg::*; #(
    parameter int PANEL_WIDTH  = 16,
    parameter int PANEL_HEIGHT = 8
) (
    input  wire            clk,
    input  wire            reset,
    input  wire            enable,
    input  wire draw_cmd_t rect,
    output fb_write_t      write,
    output logic           done
);

    typedef enum logic [2:0] {
        ST_START,
        ST_CLIP,
        ST_RUNNING,
        ST_PREDONE,
        ST_DONE
    } ctrl_state_t;

    ctrl_state_t state;
    logic        subcmd_enable;
    logic        local_reset;
    logic        fill_done;
    logic [6:0]  room_w;
    logic [5:0]  room_h;
    logic [6:0]  clip_width;
    logic [5:0]  clip_height;

    // Space left between the origin and the right and bottom edges.
    assign room_w = 7'(PANEL_WIDTH) - {1'b0, rect.x1};
    assign room_h = 6'(PANEL_HEIGHT) - {1'b0, rect.y1};

    always_ff @(posedge clk) begin
        if (state == ST_START && enable) begin
            if ({1'b0, rect.x1} >= 7'(PANEL_WIDTH)) begin
                clip_width <= 7'd0;
            end else begin
                clip_width <= (rect.width < room_w) ? rect.width : room_w;
            end
            if ({1'b0, rect.y1} >= 6'(PANEL_HEIGHT)) begin
                clip_height <= 6'd0;
            end else begin
                clip_height <= (rect.height < room_h) ? rect.height : room_h;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= ST_START;
            subcmd_enable <= 1'b0;
            local_reset   <= 1'b0;
            done          <= 1'b0;
        end else begin
            case (state)
                ST_START: begin
                    if (enable) begin
                        state <= ST_CLIP;
                    end
                end
                ST_CLIP: begin
                    subcmd_enable <= 1'b1; // Clipped size is stable from here on.
                    state         <= ST_RUNNING;
                end
                ST_RUNNING: begin
                    if (enable && fill_done) begin
                        subcmd_enable <= 1'b0;
                        state         <= ST_PREDONE;
                    end
                end
                ST_PREDONE: begin
                    if (enable) begin
                        done        <= 1'b1;
                        local_reset <= 1'b1;
                        state       <= ST_DONE;
                    end
                end
                default: begin
                    done        <= 1'b0;
                    local_reset <= 1'b0;
                    state       <= ST_START;
                end
            endcase
        end
    end

    subcmd_fillarea u_fill (
        .clk    (clk),
        .reset  (reset),
        .enable (subcmd_enable),
        .ack    (local_reset),
        .x1     (rect.x1),
        .y1     (rect.y1),
        .width  (clip_width),
        .height (clip_height),
        .color  (rect.color),
        .write  (write),
        .done   (fill_done)
    );

endmodule

`default_nettype wire

// ==== design/cmd_dispatch.sv ====
/* Drawing command dispatcher */
`timescale 1ns/1ps
`default_nettype none

module cmd_dispatch import panel_pkg::*; (
    input  wire            clk,
    input  wire            reset,
    input  wire            cmd_valid,
    input  wire draw_cmd_t cmd,
    output logic           busy,
    output logic           done,
    output logic           blank_enable,
    output logic           fill_enable,
    output draw_cmd_t      fill_cmd,
    input  wire            blank_done,
    input  wire            fill_done,
    input  wire fb_write_t blank_write,
    input  wire fb_write_t fill_write,
    output fb_write_t      fb_write
);

    logic accept;
    logic finish;

    // Strobes that arrive while a command runs are dropped.
    assign accept = cmd_valid && !busy;
    assign finish = (blank_enable && blank_done) || (fill_enable && fill_done);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy         <= 1'b0;
            done         <= 1'b0;
            blank_enable <= 1'b0;
            fill_enable  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                busy         <= 1'b1;
                blank_enable <= (cmd.op == CMD_BLANK);
                fill_enable  <= (cmd.op == CMD_FILLRECT);
            end else if (finish) begin
                busy         <= 1'b0;
                done         <= 1'b1;
                blank_enable <= 1'b0;
                fill_enable  <= 1'b0;
            end
        end
    end

    // The fill controller reads the rectangle as a steady level.
    always_ff @(posedge clk) begin
        if (accept) begin
            fill_cmd <= cmd;
        end
    end

    // While idle both bundles are quiet, so the blank side is forwarded.
    assign fb_write = fill_enable ? fill_write : blank_write;

endmodule

`default_nettype wire

// ==== design/framebuffer_ram.sv ====
/* Byte wide framebuffer */
`timescale 1ns/1ps
`default_nettype none

module framebuffer_ram import panel_pkg::*; #(
    parameter int PANEL_WIDTH  = 16,
    parameter int PANEL_HEIGHT = 8
) (
    input  wire            clk,
    input  wire fb_write_t fb_write,
    input  wire fb_addr_t  rd_addr,
    output logic [7:0]     rd_data
);

    localparam int DEPTH  = 3 * PANEL_WIDTH * PANEL_HEIGHT;
    localparam int ADDR_W = $clog2(DEPTH);

    logic [7:0]        mem [DEPTH];
    logic [ADDR_W-1:0] wr_idx;
    logic [ADDR_W-1:0] rd_idx;
    logic              wr_in_range;
    logic              rd_in_range;

    // Pixels are stored row by row, three bytes each.
    function automatic int byte_index(fb_addr_t a);
        return (int'(a.row) * PANEL_WIDTH + int'(a.col)) * 3 + int'(a.pixel);
    endfunction

    function automatic logic in_range(fb_addr_t a);
        return (int'(a.row) < PANEL_HEIGHT) && (int'(a.col) < PANEL_WIDTH) &&
               (a.pixel != 2'd3);
    endfunction

    assign wr_idx      = ADDR_W'(byte_index(fb_write.addr));
    assign rd_idx      = ADDR_W'(byte_index(rd_addr));
    assign wr_in_range = in_range(fb_write.addr);
    assign rd_in_range = in_range(rd_addr);

    always_ff @(posedge clk) begin
        if (fb_write.write_enable && wr_in_range) begin
            mem[wr_idx] <= fb_write.data;
        end
        rd_data <= rd_in_range ? mem[rd_idx] : 8'h00; // Old data on a same-cycle write.
    end

endmodule

`default_nettype wire

// ==== design/panel_ctrl_top.sv ====
/* LED panel drawing engine */
`timescale 1ns/1ps
`default_nettype none

module panel_ctrl_top import panel_pkg::*; #(
    parameter int PANEL_WIDTH  = 16,
    parameter int PANEL_HEIGHT = 8
) (
    input  wire            clk,
    input  wire            reset,
    input  wire            cmd_valid,
    input  wire draw_cmd_t cmd,
    output logic           busy,
    output logic           done,
    input  wire fb_addr_t  rd_addr,
    output logic [7:0]     rd_data
);

    // The address fields cannot reach beyond the package limits.
    localparam int FB_WIDTH  = (PANEL_WIDTH > MAX_WIDTH) ? MAX_WIDTH : PANEL_WIDTH;
    localparam int FB_HEIGHT = (PANEL_HEIGHT > MAX_HEIGHT) ? MAX_HEIGHT : PANEL_HEIGHT;

    logic      blank_enable;
    logic      fill_enable;
    logic      blank_done;
    logic      fill_done;
    draw_cmd_t fill_cmd;
    fb_write_t blank_write;
    fb_write_t fill_write;
    fb_write_t fb_write;

    cmd_dispatch u_dispatch (
        .clk          (clk),
        .reset        (reset),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .busy         (busy),
        .done         (done),
        .blank_enable (blank_enable),
        .fill_enable  (fill_enable),
        .fill_cmd     (fill_cmd),
        .blank_done   (blank_done),
        .fill_done    (fill_done),
        .blank_write  (blank_write),
        .fill_write   (fill_write),
        .fb_write     (fb_write)
    );

    cmd_blankpanel #(.PANEL_WIDTH(FB_WIDTH), .PANEL_HEIGHT(FB_HEIGHT)) u_blank (
        .clk    (clk),
        .reset  (reset),
        .enable (blank_enable),
        .write  (blank_write),
        .done   (blank_done)
    );

    cmd_fillrect #(.PANEL_WIDTH(FB_WIDTH), .PANEL_HEIGHT(FB_HEIGHT)) u_fillrect (
        .clk    (clk),
        .reset  (reset),
        .enable (fill_enable),
        .rect   (fill_cmd),
        .write  (fill_write),
        .done   (fill_done)
    );

    framebuffer_ram #(.PANEL_WIDTH(FB_WIDTH), .PANEL_HEIGHT(FB_HEIGHT)) u_fb (
        .clk      (clk),
        .fb_write (fb_write),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

endmodule

`default_nettype wire

// ==== sim/panel_ctrl_tb.sv ====
/* Panel drawing engine testbench */
`timescale 1ns/1ps
`default_nettype none

module panel_ctrl_tb import panel_pkg::*; ();

    localparam int PW       = 16;
    localparam int PH       = 8;
    localparam int NUM_CMDS = 15;

    typedef struct {
        draw_cmd_t cmd;
        logic      inject; // Strobe a second command while this one runs.
    } test_entry_t;

    logic        clk;
    logic        reset;
    logic        cmd_valid;
    draw_cmd_t   cmd;
    logic        busy;
    logic        done;
    fb_addr_t    rd_addr;
    logic [7:0]  rd_data;

    test_entry_t table_entries [NUM_CMDS];
    logic [7:0]  model [PH][PW][3];
    logic [31:0] lcg_state;
    int          cycle_count;
    int          cycle_limit;
    int          done_count;
    int          accepted;

    panel_ctrl_top #(.PANEL_WIDTH(PW), .PANEL_HEIGHT(PH)) UUT (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .done      (done),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    always #5 clk = ~clk;

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int rand_below(input int n);
        lcg_state = lcg_next(lcg_state);
        return int'(lcg_state[30:16]) % n;
    endfunction

    function automatic draw_cmd_t make_cmd(input cmd_op_t op, input int x1, input int y1,
                                           input int w, input int h, input logic [23:0] rgb);
        draw_cmd_t c;
        c.op     = op;
        c.x1     = col_addr_t'(x1);
        c.y1     = row_addr_t'(y1);
        c.width  = 7'(w);
        c.height = 6'(h);
        c.color  = color_t'(rgb);
        return c;
    endfunction

    // Reference model of the panel, clipped at the right and bottom edges.
    task automatic apply_to_model(input draw_cmd_t c);
        int w;
        int h;
        if (c.op == CMD_BLANK) begin
            foreach (model[r, x, p]) model[r][x][p] = 8'h00;
        end else begin
            w = (int'(c.x1) >= PW) ? 0 : ((int'(c.width) < PW - int'(c.x1)) ?
                int'(c.width) : PW - int'(c.x1));
            h = (int'(c.y1) >= PH) ? 0 : ((int'(c.height) < PH - int'(c.y1)) ?
                int'(c.height) : PH - int'(c.y1));
            for (int r = 0; r < h; r++) begin
                for (int x = 0; x < w; x++) begin
                    model[int'(c.y1) + r][int'(c.x1) + x][0] = c.color.r;
                    model[int'(c.y1) + r][int'(c.x1) + x][1] = c.color.g;
                    model[int'(c.y1) + r][int'(c.x1) + x][2] = c.color.b;
                end
            end
        end
    endtask

    task automatic check_framebuffer();
        fb_addr_t a;
        for (int r = 0; r < PH; r++) begin
            for (int x = 0; x < PW; x++) begin
                for (int p = 0; p < 3; p++) begin
                    a.row   = row_addr_t'(r);
                    a.col   = col_addr_t'(x);
                    a.pixel = pixel_sel_t'(p);
                    rd_addr = a;
                    @(negedge clk);
                    assert (rd_data === model[r][x][p]) else report_failure($sformatf(
                        "mismatch rd_data row %0d col %0d pixel %0d: expected %h got %h",
                        r, x, p, model[r][x][p], rd_data));
                end
            end
        end
    endtask

    // Called on a falling edge; returns on the falling edge that sees done.
    task automatic run_command(input draw_cmd_t c, input logic inject);
        int waited;
        waited    = 0;
        cmd       = c;
        cmd_valid = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
        cmd       = '0;
        assert (busy === 1'b1) else
            report_failure($sformatf("mismatch busy: expected %h got %h", 1'b1, busy));
        while (done !== 1'b1) begin
            if (inject && waited == 2) begin
                cmd       = make_cmd(CMD_FILLRECT, 0, 0, PW, PH, 24'hDEADBE);
                cmd_valid = 1'b1; // Must be dropped by the engine.
            end else begin
                cmd       = '0;
                cmd_valid = 1'b0;
            end
            @(negedge clk);
            waited++;
        end
        cmd_valid = 1'b0;
        cmd       = '0;
        assert (busy === 1'b0) else
            report_failure($sformatf("mismatch busy: expected %h got %h", 1'b0, busy));
        accepted++;
    endtask

    always @(posedge clk) begin
        cycle_count++;
        assert (cycle_count < cycle_limit) else
            report_failure("timeout, the engine stopped making progress");
    end

    always @(negedge clk) begin
        if (!reset && done === 1'b1) begin
            done_count++;
        end
    end

    initial begin
        int i;
        clk         = 1'b0;
        reset       = 1'b1;
        cmd_valid   = 1'b0;
        cmd         = '0;
        rd_addr     = '0;
        cycle_count = 0;
        done_count  = 0;
        accepted    = 0;
        lcg_state   = 32'd26;
        foreach (model[r, x, p]) model[r][x][p] = 8'h00;

        table_entries[0]  = '{make_cmd(CMD_BLANK, 0, 0, 0, 0, 24'h0), 1'b0};
        table_entries[1]  = '{make_cmd(CMD_FILLRECT, 2, 1, 4, 3, 24'h112233), 1'b0};
        table_entries[2]  = '{make_cmd(CMD_FILLRECT, 12, 5, 10, 10, 24'hA5B6C7), 1'b0};
        table_entries[3]  = '{make_cmd(CMD_FILLRECT, 20, 2, 3, 3, 24'hFFFFFF), 1'b0};
        table_entries[4]  = '{make_cmd(CMD_FILLRECT, 0, 9, 3, 2, 24'h445566), 1'b0};
        table_entries[5]  = '{make_cmd(CMD_FILLRECT, 3, 3, 0, 4, 24'h778899), 1'b0};
        table_entries[6]  = '{make_cmd(CMD_FILLRECT, 5, 2, 3, 0, 24'hAABBCC), 1'b0};
        table_entries[7]  = '{make_cmd(CMD_FILLRECT, 0, 0, PW, PH, 24'h0F1E2D), 1'b1};
        for (i = 8; i < 14; i++) begin
            table_entries[i].cmd = make_cmd(CMD_FILLRECT, rand_below(20), rand_below(10),
                                            rand_below(18), rand_below(10),
                                            {8'(rand_below(256)), 8'(rand_below(256)),
                                             8'(rand_below(256))});
            table_entries[i].inject = 1'b0;
        end
        table_entries[14] = '{make_cmd(CMD_BLANK, 0, 0, 0, 0, 24'h0), 1'b1};

        // Fill time per command plus a full readback after each one, doubled.
        cycle_limit = 20 + (NUM_CMDS + 1) * (3 * PW * PH + 4);
        for (i = 0; i < NUM_CMDS; i++) begin
            if (table_entries[i].cmd.op == CMD_BLANK) begin
                cycle_limit += 3 * PW * PH + 20;
            end else begin
                cycle_limit += 3 * int'(table_entries[i].cmd.width) *
                               int'(table_entries[i].cmd.height) + 20;
            end
        end
        cycle_limit *= 2;

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        assert (busy === 1'b0) else
            report_failure($sformatf("mismatch busy: expected %h got %h", 1'b0, busy));
        assert (done === 1'b0) else
            report_failure($sformatf("mismatch done: expected %h got %h", 1'b0, done));

        for (i = 0; i < NUM_CMDS; i++) begin
            run_command(table_entries[i].cmd, table_entries[i].inject);
            apply_to_model(table_entries[i].cmd);
            check_framebuffer();
        end

        @(negedge clk);
        assert (done_count == accepted) else report_failure($sformatf(
            "mismatch done_count: expected %h got %h", accepted, done_count));
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== panel_ctrl.f ====
design/panel_pkg.sv
design/subcmd_fillarea.sv
design/cmd_blankpanel.sv
design/cmd_fillrect.sv
design/cmd_dispatch.sv
design/framebuffer_ram.sv
design/panel_ctrl_top.sv
sim/panel_ctrl_tb.sv
